/* src/fp_wb_cfg.svh */
// FP writeback configuration: data width, id width, unit count and result FIFO depth
`ifndef FP_WB_CFG_SVH
`define FP_WB_CFG_SVH

// Single-precision word width
`define FP_WB_FLEN 32

// Rolling instruction id width
// Must cover more ids than the total number of credits
`define FP_WB_ID_W 3

// Execution units on the writeback arbiter
// Unit 0 is sign injection, unit 1 is min/max
`define FP_WB_NUM_UNITS 2

// Result FIFO slots per unit
// Also the initial credit count per unit in the issue stage
// 2 units x 2 slots = 4 ids in flight, below the 8-id range
`define FP_WB_FIFO_DEPTH 2

`endif

/* src/fp_wb_pkg.sv */
// FP writeback types: ids, words, flags, operation encodings and the shared packets
`default_nettype none

`include "fp_wb_cfg.svh"

package fp_wb_pkg;

    typedef logic [`FP_WB_ID_W-1:0] id_t;
    typedef logic [`FP_WB_FLEN-1:0] flen_t;

    // Exception flags, RISC-V fflags bit order with NV at the top
    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    // Supported operations
    typedef enum logic [2:0] {
        OP_FSGNJ  = 3'd0,
        OP_FSGNJN = 3'd1,
        OP_FSGNJX = 3'd2,
        OP_FMIN   = 3'd3,
        OP_FMAX   = 3'd4
    } fp_op_t;

    // One bit per unit, steering and ack
    typedef logic [`FP_WB_NUM_UNITS-1:0] unit_sel_t;

    // Unit indices on the steering and ack vectors
    localparam int UNIT_SGNJ   = 0;
    localparam int UNIT_MINMAX = 1;

    // Quiet NaN returned when both min/max operands are NaN
    localparam flen_t CANONICAL_NAN = 32'h7FC0_0000;

    // Issue stage to unit
    typedef struct packed {
        logic   valid;
        id_t    id;
        fp_op_t op;
        flen_t  rs1;
        flen_t  rs2;
    } fp_issue_t;

    // Result FIFO payload
    typedef struct packed {
        id_t     id;
        flen_t   rd;
        fflags_t fflags;
    } unit_result_t;

    // Register-file writeback and snoop packet
    typedef struct packed {
        logic  valid;
        id_t   id;
        flen_t data;
    } fp_wb_packet_t;

    // Flag writeback packet
    typedef struct packed {
        logic    valid;
        id_t     id;
        fflags_t fflags;
    } fflags_wb_t;

endpackage

`default_nettype wire

/* src/result_fifo.sv */
// Result FIFO: small synchronous circular buffer holding one unit's finished results
`timescale 1ns/1ps
`default_nettype none

module result_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     not_empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Push with pop keeps the count
            case ({push, pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);

endmodule

`default_nettype wire

/* src/fp_issue.sv */
// FP issue stage: accepts outside ops, stamps rolling ids, steers to units on credits
`timescale 1ns/1ps
`default_nettype none

`include "fp_wb_cfg.svh"

module fp_issue
    import fp_wb_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  fp_op_t    in_op,
    input  flen_t     in_rs1,
    input  flen_t     in_rs2,
    output logic      in_ready,
    output fp_issue_t sgnj_issue,
    output fp_issue_t minmax_issue,
    input  unit_sel_t unit_ack
);

    localparam int CRED_W = $clog2(`FP_WB_FIFO_DEPTH + 1);

    logic [CRED_W-1:0] credit [`FP_WB_NUM_UNITS];
    unit_sel_t         op_sel;
    unit_sel_t         has_credit;
    unit_sel_t         issue_sel;
    logic              accept;
    id_t               next_id;
    id_t               id_q;
    fp_op_t            op_q;
    flen_t             rs1_q;
    flen_t             rs2_q;
    unit_sel_t         issue_vld_q;

    ////////////////////////////////////////////////////////////
    // Op steering and acceptance

    // Min/max ops go to unit 1, all sign-injection ops to unit 0
    always_comb begin
        op_sel = '0;
        if (in_op == OP_FMIN || in_op == OP_FMAX) begin
            op_sel[UNIT_MINMAX] = 1'b1;
        end else begin
            op_sel[UNIT_SGNJ] = 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < `FP_WB_NUM_UNITS; i++) begin
            has_credit[i] = (credit[i] != '0);
        end
    end

    // Ready only when the target unit has a free result slot
    // Held low while in reset
    assign in_ready  = ~rst & (|(op_sel & has_credit));
    assign accept    = in_valid & in_ready;
    assign issue_sel = accept ? op_sel : '0;

    ////////////////////////////////////////////////////////////
    // Credits and id counter

    // One credit per result FIFO slot, returned on arbiter ack
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `FP_WB_NUM_UNITS; i++) begin
                credit[i] <= CRED_W'(`FP_WB_FIFO_DEPTH);
            end
        end else begin
            for (int i = 0; i < `FP_WB_NUM_UNITS; i++) begin
                case ({issue_sel[i], unit_ack[i]})
                    2'b10:   credit[i] <= credit[i] - CRED_W'(1);
                    2'b01:   credit[i] <= credit[i] + CRED_W'(1);
                    default: credit[i] <= credit[i];
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            next_id <= '0;
        end else if (accept) begin
            next_id <= next_id + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Registered issue packets

    // Per-unit valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_vld_q <= '0;
        end else begin
            issue_vld_q <= issue_sel;
        end
    end

    // Shared payload, both units see the same operands
    always_ff @(posedge clk) begin
        if (accept) begin
            id_q  <= next_id;
            op_q  <= in_op;
            rs1_q <= in_rs1;
            rs2_q <= in_rs2;
        end
    end

    always_comb begin
        sgnj_issue.valid   = issue_vld_q[UNIT_SGNJ];
        sgnj_issue.id      = id_q;
        sgnj_issue.op      = op_q;
        sgnj_issue.rs1     = rs1_q;
        sgnj_issue.rs2     = rs2_q;
        minmax_issue       = sgnj_issue;
        minmax_issue.valid = issue_vld_q[UNIT_MINMAX];
    end

endmodule

`default_nettype wire

/* src/fp_sgnj_unit.sv */
// FP sign-injection unit: single-stage FSGNJ, FSGNJN and FSGNJX with a result FIFO
`timescale 1ns/1ps
`default_nettype none

`include "fp_wb_cfg.svh"

module fp_sgnj_unit
    import fp_wb_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  fp_issue_t    issue,
    input  logic         ack,
    output logic         done,
    output unit_result_t result
);

    logic         sign_a;
    logic         sign_b;
    logic         new_sign;
    unit_result_t res_d;

    assign sign_a = issue.rs1[`FP_WB_FLEN-1];
    assign sign_b = issue.rs2[`FP_WB_FLEN-1];

    // Sign source per op
    always_comb begin
        case (issue.op)
            OP_FSGNJN: new_sign = ~sign_b;
            OP_FSGNJX: new_sign = sign_a ^ sign_b;
            default:   new_sign = sign_b;
        endcase
    end

    // Exponent and mantissa always from rs1
    always_comb begin
        res_d.id     = issue.id;
        res_d.rd     = {new_sign, issue.rs1[`FP_WB_FLEN-2:0]};
        // Sign injection never raises exceptions
        res_d.fflags = '0;
    end

    // Written on the accept edge, visible at the head next cycle
    result_fifo #(
        .payload_t (unit_result_t),
        .DEPTH     (`FP_WB_FIFO_DEPTH)
    ) result_fifo_i (
        .clk       (clk),
        .rst       (rst),
        .push      (issue.valid),
        .push_data (res_d),
        .pop       (ack),
        .head      (result),
        .not_empty (done)
    );

endmodule

`default_nettype wire

/* src/fp_minmax_unit.sv */
// FP min/max unit: two-stage FMIN/FMAX with RISC-V NaN rules, invalid flag and a result FIFO
`timescale 1ns/1ps
`default_nettype none

`include "fp_wb_cfg.svh"

module fp_minmax_unit
    import fp_wb_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  fp_issue_t    issue,
    input  logic         ack,
    output logic         done,
    output unit_result_t result
);

    localparam int EXP_W  = 8;
    localparam int MANT_W = `FP_WB_FLEN - EXP_W - 1;

    logic         a_nan;
    logic         b_nan;
    logic         a_snan;
    logic         b_snan;
    logic         a_lt_b;
    logic         s1_valid;
    id_t          s1_id;
    logic         s1_is_min;
    flen_t        s1_rs1;
    flen_t        s1_rs2;
    logic         s1_a_nan;
    logic         s1_b_nan;
    logic         s1_snan;
    logic         s1_a_lt_b;
    logic         pick_a;
    unit_result_t res_d;

    ////////////////////////////////////////////////////////////
    // Stage 1: operand classification

    // NaN: all-ones exponent with nonzero mantissa
    // Quiet when the top mantissa bit is set
    always_comb begin
        a_nan  = (&issue.rs1[`FP_WB_FLEN-2 -: EXP_W]) && (issue.rs1[MANT_W-1:0] != '0);
        b_nan  = (&issue.rs2[`FP_WB_FLEN-2 -: EXP_W]) && (issue.rs2[MANT_W-1:0] != '0);
        a_snan = a_nan && !issue.rs1[MANT_W-1];
        b_snan = b_nan && !issue.rs2[MANT_W-1];
    end

    // Value order from sign and magnitude
    // Differing signs put the negative one below, so -0 < +0
    always_comb begin
        if (issue.rs1[`FP_WB_FLEN-1] != issue.rs2[`FP_WB_FLEN-1]) begin
            a_lt_b = issue.rs1[`FP_WB_FLEN-1];
        end else if (issue.rs1[`FP_WB_FLEN-1]) begin
            a_lt_b = issue.rs1[`FP_WB_FLEN-2:0] > issue.rs2[`FP_WB_FLEN-2:0];
        end else begin
            a_lt_b = issue.rs1[`FP_WB_FLEN-2:0] < issue.rs2[`FP_WB_FLEN-2:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_id     <= issue.id;
        s1_is_min <= (issue.op == OP_FMIN);
        s1_rs1    <= issue.rs1;
        s1_rs2    <= issue.rs2;
        s1_a_nan  <= a_nan;
        s1_b_nan  <= b_nan;
        s1_snan   <= a_snan | b_snan;
        s1_a_lt_b <= a_lt_b;
    end

    ////////////////////////////////////////////////////////////
    // Stage 2: result select, registered by the FIFO write

    // FMIN keeps the smaller, FMAX the larger
    assign pick_a = s1_is_min ? s1_a_lt_b : !s1_a_lt_b;

    always_comb begin
        res_d.id        = s1_id;
        res_d.fflags    = '0;
        res_d.fflags.nv = s1_snan;
        if (s1_a_nan && s1_b_nan) begin
            res_d.rd = CANONICAL_NAN;
        end else if (s1_a_nan) begin
            res_d.rd = s1_rs2;
        end else if (s1_b_nan) begin
            res_d.rd = s1_rs1;
        end else begin
            res_d.rd = pick_a ? s1_rs1 : s1_rs2;
        end
    end

    // Stage-1 op already holds a credit, so the FIFO has room
    result_fifo #(
        .payload_t (unit_result_t),
        .DEPTH     (`FP_WB_FIFO_DEPTH)
    ) result_fifo_i (
        .clk       (clk),
        .rst       (rst),
        .push      (s1_valid),
        .push_data (res_d),
        .pop       (ack),
        .head      (result),
        .not_empty (done)
    );

endmodule

`default_nettype wire

/* src/fp_wb_arbiter.sv */
// FP writeback arbiter: fixed-priority result select, unit ack, flag packet, fcsr and snoop
`timescale 1ns/1ps
`default_nettype none

`include "fp_wb_cfg.svh"

module fp_wb_arbiter
    import fp_wb_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  unit_sel_t     unit_done,
    input  unit_result_t  unit_result [`FP_WB_NUM_UNITS],
    output unit_sel_t     unit_ack,
    output fp_wb_packet_t wb_packet,
    output fp_wb_packet_t wb_snoop,
    output fflags_wb_t    fflags_wb,
    output fflags_t       fcsr_flags
);

    localparam int SEL_W = (`FP_WB_NUM_UNITS > 1) ? $clog2(`FP_WB_NUM_UNITS) : 1;

    logic [SEL_W-1:0] sel;
    logic             any_done;

    ////////////////////////////////////////////////////////////
    // Unit select

    // Walk down from the top so the lowest done index wins
    always_comb begin
        sel = '0;
        for (int i = `FP_WB_NUM_UNITS - 1; i >= 0; i--) begin
            if (unit_done[i]) begin
                sel = SEL_W'(i);
            end
        end
    end

    assign any_done = |unit_done;

    // Writeback, flag packet and ack in the select cycle
    always_comb begin
        wb_packet.valid  = any_done;
        wb_packet.id     = unit_result[sel].id;
        wb_packet.data   = unit_result[sel].rd;

        fflags_wb.valid  = any_done;
        fflags_wb.id     = unit_result[sel].id;
        fflags_wb.fflags = unit_result[sel].fflags;

        unit_ack         = '0;
        unit_ack[sel]    = any_done;
    end

    ////////////////////////////////////////////////////////////
    // Store forwarding snoop, one cycle behind writeback

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_snoop.valid <= 1'b0;
        end else begin
            wb_snoop.valid <= wb_packet.valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_snoop.id   <= wb_packet.id;
        wb_snoop.data <= wb_packet.data;
    end

    ////////////////////////////////////////////////////////////
    // Accumulated exception flags

    // Sticky until reset
    always_ff @(posedge clk) begin
        if (rst) begin
            fcsr_flags <= '0;
        end else if (fflags_wb.valid) begin
            fcsr_flags <= fcsr_flags | fflags_wb.fflags;
        end
    end

endmodule

`default_nettype wire

/* src/fp_wb_top.sv */
// FP writeback subsystem top: issue stage, sign-injection and min/max units, writeback arbiter
`timescale 1ns/1ps
`default_nettype none

`include "fp_wb_cfg.svh"

module fp_wb_top
    import fp_wb_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          in_valid,
    input  fp_op_t        in_op,
    input  flen_t         in_rs1,
    input  flen_t         in_rs2,
    output logic          in_ready,
    output fp_wb_packet_t wb_packet,
    output fp_wb_packet_t wb_snoop,
    output fflags_wb_t    fflags_wb,
    output fflags_t       fcsr_flags
);

    fp_issue_t    sgnj_issue;
    fp_issue_t    minmax_issue;
    unit_sel_t    unit_done;
    unit_sel_t    unit_ack;
    unit_result_t unit_result [`FP_WB_NUM_UNITS];

    // Ack doubles as the credit return
    fp_issue fp_issue_i (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_op        (in_op),
        .in_rs1       (in_rs1),
        .in_rs2       (in_rs2),
        .in_ready     (in_ready),
        .sgnj_issue   (sgnj_issue),
        .minmax_issue (minmax_issue),
        .unit_ack     (unit_ack)
    );

    fp_sgnj_unit fp_sgnj_unit_i (
        .clk    (clk),
        .rst    (rst),
        .issue  (sgnj_issue),
        .ack    (unit_ack[UNIT_SGNJ]),
        .done   (unit_done[UNIT_SGNJ]),
        .result (unit_result[UNIT_SGNJ])
    );

    fp_minmax_unit fp_minmax_unit_i (
        .clk    (clk),
        .rst    (rst),
        .issue  (minmax_issue),
        .ack    (unit_ack[UNIT_MINMAX]),
        .done   (unit_done[UNIT_MINMAX]),
        .result (unit_result[UNIT_MINMAX])
    );

    fp_wb_arbiter fp_wb_arbiter_i (
        .clk         (clk),
        .rst         (rst),
        .unit_done   (unit_done),
        .unit_result (unit_result),
        .unit_ack    (unit_ack),
        .wb_packet   (wb_packet),
        .wb_snoop    (wb_snoop),
        .fflags_wb   (fflags_wb),
        .fcsr_flags  (fcsr_flags)
    );

endmodule

`default_nettype wire

/* verification/fp_wb_tb.sv */
// Testbench for the FP writeback subsystem: table-driven ops, id scoreboard, snoop and fcsr checks
`timescale 1ns/1ps
`default_nettype none

`include "fp_wb_cfg.svh"

module fp_wb_tb
    import fp_wb_pkg::*;
();

    localparam int NUM_ROWS       = 22;
    localparam int NUM_IDS        = 1 << `FP_WB_ID_W;
    localparam int TIMEOUT_CYCLES = 40 * NUM_ROWS + 50;

    localparam fflags_t NO_FLAGS = 5'b00000;
    localparam fflags_t NV_FLAG  = 5'b10000;

    // One operation and its hand-derived result
    typedef struct packed {
        fp_op_t  op;
        flen_t   rs1;
        flen_t   rs2;
        flen_t   rd;
        fflags_t fl;
    } test_row_t;

    localparam test_row_t ROWS [NUM_ROWS] = '{
        // Sign injection on mixed signs
        '{OP_FSGNJ,  32'h3F80_0000, 32'hC000_0000, 32'hBF80_0000, NO_FLAGS},
        '{OP_FSGNJN, 32'h3F80_0000, 32'hC000_0000, 32'h3F80_0000, NO_FLAGS},
        '{OP_FSGNJX, 32'hBF80_0000, 32'hC000_0000, 32'h3F80_0000, NO_FLAGS},
        '{OP_FSGNJX, 32'h4049_0FDB, 32'h8000_0000, 32'hC049_0FDB, NO_FLAGS},
        '{OP_FSGNJN, 32'hC120_0000, 32'h3F80_0000, 32'hC120_0000, NO_FLAGS},
        // Ordinary min/max, back to back so credits run out
        '{OP_FMIN,   32'h3F80_0000, 32'h4000_0000, 32'h3F80_0000, NO_FLAGS},
        '{OP_FMAX,   32'h3F80_0000, 32'h4000_0000, 32'h4000_0000, NO_FLAGS},
        '{OP_FMIN,   32'hC040_0000, 32'hBF80_0000, 32'hC040_0000, NO_FLAGS},
        '{OP_FMAX,   32'hC040_0000, 32'hBF80_0000, 32'hBF80_0000, NO_FLAGS},
        // Signed zeros, -0 below +0
        '{OP_FMIN,   32'h0000_0000, 32'h8000_0000, 32'h8000_0000, NO_FLAGS},
        '{OP_FMAX,   32'h8000_0000, 32'h0000_0000, 32'h0000_0000, NO_FLAGS},
        '{OP_FMAX,   32'h3F80_0000, 32'hC2C8_0000, 32'h3F80_0000, NO_FLAGS},
        // One quiet NaN gives the other operand
        '{OP_FMIN,   32'h7FC0_0000, 32'h40A0_0000, 32'h40A0_0000, NO_FLAGS},
        '{OP_FMAX,   32'hC000_0000, 32'h7FC0_0001, 32'hC000_0000, NO_FLAGS},
        '{OP_FMIN,   32'h7FC0_0000, 32'hFFC1_2345, 32'h7FC0_0000, NO_FLAGS},
        // Signaling NaN raises NV
        '{OP_FMAX,   32'h7F80_0001, 32'h3F80_0000, 32'h3F80_0000, NV_FLAG},
        '{OP_FMIN,   32'h4000_0000, 32'hFF80_0010, 32'h4000_0000, NV_FLAG},
        '{OP_FMAX,   32'h7FA0_0000, 32'h7FC0_0000, 32'h7FC0_0000, NV_FLAG},
        // Mixed units, unit 0 wins the arbiter
        '{OP_FMIN,   32'h4120_0000, 32'h4110_0000, 32'h4110_0000, NO_FLAGS},
        '{OP_FSGNJ,  32'h4120_0000, 32'h8000_0000, 32'hC120_0000, NO_FLAGS},
        '{OP_FMAX,   32'h0080_0000, 32'h007F_FFFF, 32'h0080_0000, NO_FLAGS},
        '{OP_FMIN,   32'h8080_0000, 32'h807F_FFFF, 32'h8080_0000, NO_FLAGS}
    };

    logic          clk = 1'b0;
    logic          rst;
    logic          in_valid;
    fp_op_t        in_op;
    flen_t         in_rs1;
    flen_t         in_rs2;
    logic          in_ready;
    fp_wb_packet_t wb_packet;
    fp_wb_packet_t wb_snoop;
    fflags_wb_t    fflags_wb;
    fflags_t       fcsr_flags;

    // Scoreboard, one slot per id
    flen_t         exp_rd  [NUM_IDS];
    fflags_t       exp_fl  [NUM_IDS];
    int            exp_unit [NUM_IDS];
    logic          pending [NUM_IDS] = '{default: 1'b0};
    id_t           issue_id   = '0;
    int            accept_row = 0;
    fflags_t       acc_flags  = '0;
    fp_wb_packet_t prev_wb;
    logic          prev_ok    = 1'b0;
    logic          fcsr_due   = 1'b0;
    fp_wb_packet_t exp_pkt;
    fflags_wb_t    exp_fwb;

    // Free result slots per unit as the credits should count them
    int model_credit [`FP_WB_NUM_UNITS] = '{default: `FP_WB_FIFO_DEPTH};

    int wb_count     = 0;
    int cycle_count  = 0;
    int gap;
    int err_wb       = 0;
    int err_flags    = 0;
    int err_fcsr     = 0;
    int err_ready    = 0;
    int err_other    = 0;
    int left_pending = 0;
    int total_errors;

    always #20 clk = ~clk;

    fp_wb_top fp_wb_top_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_rs1     (in_rs1),
        .in_rs2     (in_rs2),
        .in_ready   (in_ready),
        .wb_packet  (wb_packet),
        .wb_snoop   (wb_snoop),
        .fflags_wb  (fflags_wb),
        .fcsr_flags (fcsr_flags)
    );

    ////////////////////////////////////////////////////////////
    // Compare tasks

    // Payload only matters when the packet is valid
    task automatic check_wb(input string what, input fp_wb_packet_t got, input fp_wb_packet_t exp);
        if (got.valid !== exp.valid ||
            (exp.valid && (got.id !== exp.id || got.data !== exp.data))) begin
            $display("ERROR %0t: %s valid %b id %0d data %h, expected valid %b id %0d data %h",
                     $time, what, got.valid, got.id, got.data, exp.valid, exp.id, exp.data);
            err_wb++;
        end
    endtask

    task automatic check_flags(input fflags_wb_t got, input fflags_wb_t exp);
        if (got.valid !== exp.valid ||
            (exp.valid && (got.id !== exp.id || got.fflags !== exp.fflags))) begin
            $display("ERROR %0t: fflags_wb valid %b id %0d flags %b, expected %b %0d %b",
                     $time, got.valid, got.id, got.fflags, exp.valid, exp.id, exp.fflags);
            err_flags++;
        end
    endtask

    task automatic check_fcsr(input fflags_t got, input fflags_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: fcsr_flags %b, expected %b", $time, got, exp);
            err_fcsr++;
        end
    endtask

    task automatic compare_ready(input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t: in_ready %b, expected %b", $time, got, exp);
            err_ready++;
        end
    endtask

    // Min/max ops run on unit 1, sign injection on unit 0
    function automatic int target_unit(input fp_op_t op);
        if (op == OP_FMIN || op == OP_FMAX) begin
            return UNIT_MINMAX;
        end
        return UNIT_SGNJ;
    endfunction

    // Next table row goes under the id the issue stage stamps
    task automatic record_issue(input int r);
        if (pending[issue_id]) begin
            $display("Id %0d was reused while its earlier result was still outstanding", issue_id);
            err_other++;
        end
        exp_rd[issue_id]   = ROWS[r].rd;
        exp_fl[issue_id]   = ROWS[r].fl;
        exp_unit[issue_id] = target_unit(ROWS[r].op);
        pending[issue_id]  = 1'b1;
        issue_id           = issue_id + 1'b1;
    endtask

    ////////////////////////////////////////////////////////////
    // Monitor, sampled mid-cycle when everything is settled

    always @(negedge clk) begin
        if (rst) begin
            compare_ready(in_ready, 1'b0);
            prev_ok = 1'b0;
        end else begin
            // Ready follows the credit count of the op's unit
            compare_ready(in_ready, model_credit[target_unit(in_op)] != 0);
            if (prev_ok) begin
                check_wb("wb_snoop", wb_snoop, prev_wb);
            end
            // fcsr lags the flag writeback by one cycle
            if (fcsr_due) begin
                check_fcsr(fcsr_flags, acc_flags);
            end
            fcsr_due = 1'b0;
            if (wb_packet.valid && pending[wb_packet.id]) begin
                exp_pkt.valid  = 1'b1;
                exp_pkt.id     = wb_packet.id;
                exp_pkt.data   = exp_rd[wb_packet.id];
                exp_fwb.valid  = 1'b1;
                exp_fwb.id     = wb_packet.id;
                exp_fwb.fflags = exp_fl[wb_packet.id];
                check_wb("wb_packet", wb_packet, exp_pkt);
                check_flags(fflags_wb, exp_fwb);
                acc_flags               = acc_flags | exp_fl[wb_packet.id];
                pending[wb_packet.id]   = 1'b0;
                fcsr_due                = 1'b1;
                // Writeback acks the unit and frees its slot
                model_credit[exp_unit[wb_packet.id]]++;
                wb_count++;
            end else if (wb_packet.valid) begin
                $display("Writeback at %0t for id %0d, which has no operation outstanding",
                         $time, wb_packet.id);
                err_other++;
                wb_count++;
            end else begin
                exp_fwb = '0;
                check_flags(fflags_wb, exp_fwb);
            end
            // Taken on the coming rising edge
            if (in_valid && in_ready) begin
                model_credit[target_unit(in_op)]--;
                record_issue(accept_row);
                accept_row++;
            end
            prev_ok = 1'b1;
        end
        prev_wb = wb_packet;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d of %0d results written back",
                     cycle_count, wb_count, NUM_ROWS);
            $display("Something failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus

    initial begin
        void'($urandom(61066));
        rst      = 1'b1;
        in_valid = 1'b0;
        in_op    = OP_FSGNJ;
        in_rs1   = '0;
        in_rs2   = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            gap = $urandom_range(2, 0);
            repeat (gap) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
            @(posedge clk);
            in_valid <= 1'b1;
            in_op    <= ROWS[r].op;
            in_rs1   <= ROWS[r].rs1;
            in_rs2   <= ROWS[r].rs2;
            // Hold until the target unit has a credit
            @(negedge clk);
            while (!in_ready) begin
                @(negedge clk);
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;

        while (wb_count < NUM_ROWS) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);

        for (int i = 0; i < NUM_IDS; i++) begin
            if (pending[i]) begin
                $display("Id %0d was accepted but never written back", i);
                left_pending++;
            end
        end
        total_errors = err_wb + err_flags + err_fcsr + err_ready + err_other + left_pending;
        $display("Errors: writeback %0d, flags %0d, fcsr %0d, ready %0d, other %0d, pending %0d",
                 err_wb, err_flags, err_fcsr, err_ready, err_other, left_pending);
        if (total_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+src
src/fp_wb_pkg.sv
src/result_fifo.sv
src/fp_issue.sv
src/fp_sgnj_unit.sv
src/fp_minmax_unit.sv
src/fp_wb_arbiter.sv
src/fp_wb_top.sv
verification/fp_wb_tb.sv

/* Makefile */
# Verilator build and run of the FP writeback testbench

TOP  := fp_wb_tb
SRCS := $(filter-out +%,$(shell cat project.f)) src/fp_wb_cfg.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/V$(TOP): project.f $(SRCS)
	verilator --binary --timing -j 0 --top-module $(TOP) -f project.f

# Passes only when the pass line shows up in the output
run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Everything OK'

clean:
	rm -rf obj_dir
